//--- hdl/core_pkg.sv
/*
  shared types for the integer pipeline: data word, register index,
  shift amount, ALU operation codes, MIPS32 opcode and function fields
*/

package core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [4:0]  shamt_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_nor,
		alu_slt,
		alu_sltu,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_lui
	} alu_op_e;

	// primary opcode field
	localparam logic [5:0] op_special = 6'h00;
	localparam logic [5:0] op_addiu   = 6'h09;
	localparam logic [5:0] op_slti    = 6'h0a;
	localparam logic [5:0] op_sltiu   = 6'h0b;
	localparam logic [5:0] op_andi    = 6'h0c;
	localparam logic [5:0] op_ori     = 6'h0d;
	localparam logic [5:0] op_xori    = 6'h0e;
	localparam logic [5:0] op_lui     = 6'h0f;

	// function field of special
	localparam logic [5:0] fn_sll  = 6'h00;
	localparam logic [5:0] fn_srl  = 6'h02;
	localparam logic [5:0] fn_sra  = 6'h03;
	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and  = 6'h24;
	localparam logic [5:0] fn_or   = 6'h25;
	localparam logic [5:0] fn_xor  = 6'h26;
	localparam logic [5:0] fn_nor  = 6'h27;
	localparam logic [5:0] fn_slt  = 6'h2a;
	localparam logic [5:0] fn_sltu = 6'h2b;

endpackage

//--- hdl/instr_decoder.sv
/*
  instruction decoder: field split, ALU operation, operand select,
  immediate extension and destination choice
*/
`timescale 1ns/10ps

module instr_decoder (
	input  core_pkg::word_t    instr,
	output core_pkg::reg_idx_t rs,
	output core_pkg::reg_idx_t rt,
	output core_pkg::reg_idx_t dest,
	output core_pkg::alu_op_e  alu_op,
	output logic               use_imm,
	output core_pkg::word_t    imm,
	output core_pkg::shamt_t   shamt,
	output logic               writes
);

	logic [5:0]         opcode;
	logic [5:0]         funct;
	logic [15:0]        imm16;
	core_pkg::reg_idx_t rd;
	logic               use_rd;
	logic               known;

	assign opcode = instr[31:26];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign shamt  = instr[10:6];
	assign funct  = instr[5:0];
	assign imm16  = instr[15:0];

	assign dest   = use_rd ? rd : rt;
	// r0 targets and unknown encodings become bubbles
	assign writes = known && (dest != '0);

	always_comb begin
		alu_op  = core_pkg::alu_add;
		use_imm = 1'b1;
		use_rd  = 1'b0;
		known   = 1'b1;
		imm     = {16'b0, imm16};
		case (opcode)
			core_pkg::op_special: begin
				use_imm = 1'b0;
				use_rd  = 1'b1;
				case (funct)
					core_pkg::fn_addu: alu_op = core_pkg::alu_add;
					core_pkg::fn_subu: alu_op = core_pkg::alu_sub;
					core_pkg::fn_and:  alu_op = core_pkg::alu_and;
					core_pkg::fn_or:   alu_op = core_pkg::alu_or;
					core_pkg::fn_xor:  alu_op = core_pkg::alu_xor;
					core_pkg::fn_nor:  alu_op = core_pkg::alu_nor;
					core_pkg::fn_slt:  alu_op = core_pkg::alu_slt;
					core_pkg::fn_sltu: alu_op = core_pkg::alu_sltu;
					core_pkg::fn_sll:  alu_op = core_pkg::alu_sll;
					core_pkg::fn_srl:  alu_op = core_pkg::alu_srl;
					core_pkg::fn_sra:  alu_op = core_pkg::alu_sra;
					default:           known  = 1'b0;
				endcase
			end
			core_pkg::op_addiu: begin
				alu_op = core_pkg::alu_add;
				imm    = {{16{imm16[15]}}, imm16};
			end
			core_pkg::op_slti: begin
				alu_op = core_pkg::alu_slt;
				imm    = {{16{imm16[15]}}, imm16};
			end
			core_pkg::op_sltiu: begin
				// sign extended, then compared unsigned
				alu_op = core_pkg::alu_sltu;
				imm    = {{16{imm16[15]}}, imm16};
			end
			core_pkg::op_andi: alu_op = core_pkg::alu_and;
			core_pkg::op_ori:  alu_op = core_pkg::alu_or;
			core_pkg::op_xori: alu_op = core_pkg::alu_xor;
			core_pkg::op_lui:  alu_op = core_pkg::alu_lui;
			default:           known  = 1'b0;
		endcase
	end

endmodule

//--- hdl/reg_file.sv
/*
  32 x 32 register file, two combinational read ports, one write port
*/
`timescale 1ns/10ps

module reg_file (
	input  logic               aclk,
	input  logic               rst,
	input  core_pkg::reg_idx_t raddr1,
	input  core_pkg::reg_idx_t raddr2,
	output core_pkg::word_t    rdata1,
	output core_pkg::word_t    rdata2,
	input  logic               we,
	input  core_pkg::reg_idx_t waddr,
	input  core_pkg::word_t    wdata
);

	// no storage behind r0
	core_pkg::word_t regs [1:31];

	always_ff @(posedge aclk) begin
		if (!rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

	// the pipeline must already have turned r0 writes into bubbles
	no_r0_write: assert property (@(posedge aclk) disable iff (!rst) we |-> waddr != '0)
		else $error("write to r0 requested");

endmodule

//--- hdl/operand_bypass.sv
/*
  source operand forwarding from stage 2 and stage 3 over the register file
*/
`timescale 1ns/10ps

module operand_bypass (
	input  core_pkg::reg_idx_t src,
	input  core_pkg::word_t    rf_data,
	input  logic               s2_valid,
	input  core_pkg::reg_idx_t s2_dest,
	input  core_pkg::word_t    s2_data,
	input  logic               s3_valid,
	input  core_pkg::reg_idx_t s3_dest,
	input  core_pkg::word_t    s3_data,
	output core_pkg::word_t    operand
);

	logic hit_s2;
	logic hit_s3;

	// r0 never forwards
	assign hit_s2 = s2_valid && (src != '0) && (src == s2_dest);
	assign hit_s3 = s3_valid && (src != '0) && (src == s3_dest);

	// younger result wins
	always_comb begin
		if (hit_s2) begin
			operand = s2_data;
		end else if (hit_s3) begin
			operand = s3_data;
		end else begin
			operand = rf_data;
		end
	end

endmodule

//--- hdl/alu.sv
/*
  integer ALU: add/sub, logic, set-less-than, shifts and lui
*/
`timescale 1ns/10ps

module alu (
	input  core_pkg::word_t  a,
	input  core_pkg::word_t  b,
	input  core_pkg::shamt_t shamt,
	input  core_pkg::alu_op_e op,
	output core_pkg::word_t  result
);

	always_comb begin
		case (op)
			core_pkg::alu_add:  result = a + b;
			core_pkg::alu_sub:  result = a - b;
			core_pkg::alu_and:  result = a & b;
			core_pkg::alu_or:   result = a | b;
			core_pkg::alu_xor:  result = a ^ b;
			core_pkg::alu_nor:  result = ~(a | b);
			core_pkg::alu_slt:  result = {31'b0, $signed(a) < $signed(b)};
			core_pkg::alu_sltu: result = {31'b0, a < b};
			// shifts act on b, as rt is the shifted register
			core_pkg::alu_sll:  result = b << shamt;
			core_pkg::alu_srl:  result = b >> shamt;
			core_pkg::alu_sra:  result = core_pkg::word_t'($signed(b) >>> shamt);
			core_pkg::alu_lui:  result = {b[15:0], 16'b0};
			default:            result = '0;
		endcase
	end

	// op arrives from the stage 2 register, so only decoder values are expected
	always_comb begin
		legal_op: assert (op <= core_pkg::alu_lui)
			else $error("illegal ALU operation %0d", op);
	end

endmodule

//--- hdl/pipe_core.sv
/*
  three-stage integer pipeline: instruction, operand and result registers,
  writeback back-pressure stall, operand forwarding
*/
`timescale 1ns/10ps

module pipe_core (
	input  logic               aclk,
	input  logic               rst,
	input  core_pkg::word_t    instr,
	input  logic               instr_valid,
	output logic               instr_ready,
	output logic               wb_valid,
	input  logic               wb_ready,
	output core_pkg::reg_idx_t wb_reg,
	output core_pkg::word_t    wb_data
);

	logic               stall;
	logic               ready_q;

	// stage 1
	logic               s1_valid;
	core_pkg::word_t    s1_instr;
	core_pkg::reg_idx_t dec_rs;
	core_pkg::reg_idx_t dec_rt;
	core_pkg::reg_idx_t dec_dest;
	core_pkg::alu_op_e  dec_op;
	logic               dec_use_imm;
	core_pkg::word_t    dec_imm;
	core_pkg::shamt_t   dec_shamt;
	logic               dec_writes;
	core_pkg::word_t    rf_rdata1;
	core_pkg::word_t    rf_rdata2;
	core_pkg::word_t    opnd_a;
	core_pkg::word_t    opnd_b;

	// stage 2
	logic               s2_valid;
	core_pkg::reg_idx_t s2_dest;
	core_pkg::word_t    s2_a;
	core_pkg::word_t    s2_b;
	core_pkg::shamt_t   s2_shamt;
	core_pkg::alu_op_e  s2_op;
	core_pkg::word_t    alu_result;

	// stage 3
	logic               s3_valid;
	core_pkg::reg_idx_t s3_dest;
	core_pkg::word_t    s3_data;

	assign stall       = wb_valid && !wb_ready;
	assign instr_ready = ready_q && !stall;

	assign wb_valid = s3_valid;
	assign wb_reg   = s3_dest;
	assign wb_data  = s3_data;

	always_ff @(posedge aclk) begin
		if (!rst) begin
			ready_q  <= 1'b0;
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s3_valid <= 1'b0;
			s2_op    <= core_pkg::alu_add;
		end else begin
			ready_q <= 1'b1;
			if (!stall) begin
				s1_valid <= instr_valid && instr_ready;
				// bubbles drop out here
				s2_valid <= s1_valid && dec_writes;
				s3_valid <= s2_valid;
				s2_op    <= dec_op;
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (!stall) begin
			s1_instr <= instr;
			s2_dest  <= dec_dest;
			s2_a     <= opnd_a;
			s2_b     <= dec_use_imm ? dec_imm : opnd_b;
			s2_shamt <= dec_shamt;
			s3_dest  <= s2_dest;
			s3_data  <= alu_result;
		end
	end

	instr_decoder instr_decoder_inst (
		.instr   (s1_instr),
		.rs      (dec_rs),
		.rt      (dec_rt),
		.dest    (dec_dest),
		.alu_op  (dec_op),
		.use_imm (dec_use_imm),
		.imm     (dec_imm),
		.shamt   (dec_shamt),
		.writes  (dec_writes)
	);

	// written on the writeback handshake
	reg_file reg_file_inst (
		.aclk   (aclk),
		.rst    (rst),
		.raddr1 (dec_rs),
		.raddr2 (dec_rt),
		.rdata1 (rf_rdata1),
		.rdata2 (rf_rdata2),
		.we     (wb_valid && wb_ready),
		.waddr  (s3_dest),
		.wdata  (s3_data)
	);

	operand_bypass bypass_a_inst (
		.src      (dec_rs),
		.rf_data  (rf_rdata1),
		.s2_valid (s2_valid),
		.s2_dest  (s2_dest),
		.s2_data  (alu_result),
		.s3_valid (s3_valid),
		.s3_dest  (s3_dest),
		.s3_data  (s3_data),
		.operand  (opnd_a)
	);

	operand_bypass bypass_b_inst (
		.src      (dec_rt),
		.rf_data  (rf_rdata2),
		.s2_valid (s2_valid),
		.s2_dest  (s2_dest),
		.s2_data  (alu_result),
		.s3_valid (s3_valid),
		.s3_dest  (s3_dest),
		.s3_data  (s3_data),
		.operand  (opnd_b)
	);

	alu alu_inst (
		.a      (s2_a),
		.b      (s2_b),
		.shamt  (s2_shamt),
		.op     (s2_op),
		.result (alu_result)
	);

	wb_hold: assert property (@(posedge aclk) disable iff (!rst)
		stall |=> wb_valid && $stable(wb_reg) && $stable(wb_data))
		else $error("writeback changed while back-pressured");

endmodule

//--- testbench/tb_checker.sv
/*
  reference model of the integer subset, in-order writeback comparison,
  hold check under back-pressure, reset check and per-test report
*/
`timescale 1ns/10ps

module tb_checker (
	input  logic        aclk,
	input  logic        rst,
	input  logic [31:0] instr,
	input  logic        instr_valid,
	input  logic        instr_ready,
	input  logic        wb_valid,
	input  logic        wb_ready,
	input  logic [4:0]  wb_reg,
	input  logic [31:0] wb_data,
	input  logic        test_done,
	input  int          test_num,
	output int          err_count,
	output int          wb_count,
	output int          pending
);

	logic [31:0] m_regs [32];
	// expected writebacks as register number over data
	logic [36:0] expect_q [$];
	logic        rst_q;
	logic        held;
	logic [4:0]  held_reg;
	logic [31:0] held_data;
	int          errors = 0;
	int          checks = 0;
	int          test_errors = 0;
	int          test_checks = 0;

	task automatic count_error();
		errors++;
		test_errors++;
	endtask

	// runs one instruction in MIPS32 semantics and tells whether a register is written
	function automatic logic execute(input logic [31:0] ins, output logic [4:0] d,
		output logic [31:0] v);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] se;
		logic [31:0] ze;
		logic        kept;
		a    = m_regs[ins[25:21]];
		b    = m_regs[ins[20:16]];
		se   = {{16{ins[15]}}, ins[15:0]};
		ze   = {16'h0000, ins[15:0]};
		kept = 1'b1;
		d    = ins[20:16];
		v    = '0;
		case (ins[31:26])
			6'h00: begin
				d = ins[15:11];
				case (ins[5:0])
					6'h21: v = a + b;
					6'h23: v = a - b;
					6'h24: v = a & b;
					6'h25: v = a | b;
					6'h26: v = a ^ b;
					6'h27: v = ~(a | b);
					6'h2a: v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					6'h2b: v = (a < b) ? 32'd1 : 32'd0;
					6'h00: v = b << ins[10:6];
					6'h02: v = b >> ins[10:6];
					6'h03: v = $signed(b) >>> ins[10:6];
					default: kept = 1'b0;
				endcase
			end
			6'h09: v = a + se;
			6'h0a: v = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
			6'h0b: v = (a < se) ? 32'd1 : 32'd0;
			6'h0c: v = a & ze;
			6'h0d: v = a | ze;
			6'h0e: v = a ^ ze;
			6'h0f: v = {ins[15:0], 16'h0000};
			default: kept = 1'b0;
		endcase
		return kept && (d != 5'd0);
	endfunction

	always @(posedge aclk) begin
		logic [36:0] e;
		logic [4:0]  d;
		logic [31:0] v;
		rst_q <= rst;
		if (!rst) begin
			for (int i = 0; i < 32; i++) begin
				m_regs[i] = '0;
			end
			expect_q.delete();
			held = 1'b0;
			if (rst_q === 1'b0 && (wb_valid !== 1'b0 || instr_ready !== 1'b0)) begin
				$display("wb_valid or instr_ready not low during reset at %0t", $time);
				count_error();
			end
		end else begin
			if (held && (!wb_valid || wb_reg != held_reg || wb_data != held_data)) begin
				$display("mismatch at %0t: writeback changed while back-pressured", $time);
				count_error();
			end
			if (wb_valid && wb_ready) begin
				if (expect_q.size() == 0) begin
					$display("writeback to r%0d at %0t arrived with no result expected",
						wb_reg, $time);
					count_error();
				end else begin
					e = expect_q.pop_front();
					checks++;
					test_checks++;
					if (wb_reg != e[36:32] || wb_data != e[31:0]) begin
						$display("mismatch at %0t: got r%0d = %h, expected r%0d = %h",
							$time, wb_reg, wb_data, e[36:32], e[31:0]);
						count_error();
					end
				end
			end
			held      = wb_valid && !wb_ready;
			held_reg  = wb_reg;
			held_data = wb_data;
			if (instr_valid && instr_ready) begin
				if (execute(instr, d, v)) begin
					m_regs[d] = v;
					expect_q.push_back({d, v});
				end
			end
			if (test_done) begin
				if (expect_q.size() != 0) begin
					$display("test %0d: %0d expected writebacks never arrived",
						test_num, expect_q.size());
					count_error();
					expect_q.delete();
				end
				$display("test %0d finished: %0d writebacks checked, %0d errors",
					test_num, test_checks, test_errors);
				test_checks = 0;
				test_errors = 0;
			end
		end
		err_count <= errors;
		wb_count  <= checks;
		pending   <= expect_q.size();
	end

endmodule

//--- testbench/tb_top.sv
/*
  testbench top: clock, reset, LFSR instruction stimulus, random
  writeback back-pressure, DUT and checker instances, run timeout
*/
`timescale 1ns/10ps

module tb_top;

	localparam int num_tests  = 4;
	localparam int test_len   = 200;
	localparam int max_cycles = num_tests * test_len * 8 + 100;

	// function codes of special and the immediate opcodes that are kept
	localparam logic [5:0] r_funct [11] = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
		6'h2a, 6'h2b, 6'h00, 6'h02, 6'h03};
	localparam logic [5:0] i_opcode [7] = '{6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f};

	logic        aclk = 1'b0;
	logic        rst;
	logic [31:0] instr;
	logic        instr_valid;
	logic        instr_ready;
	logic        wb_valid;
	logic        wb_ready;
	logic [4:0]  wb_reg;
	logic [31:0] wb_data;
	logic        test_done;
	int          test_num;
	int          err_count;
	int          wb_count;
	int          pending;
	logic [31:0] lfsr_state;
	int          cycles = 0;
	int          test_idx;

	always #50 aclk = ~aclk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// test 3 packs everything into r1-r3
	function automatic logic [4:0] pick_reg(input int test);
		logic [31:0] r;
		if (test == 3) begin
			r = rand_bits(2);
			return (r[1:0] == 2'd0) ? 5'd1 : {3'b000, r[1:0]};
		end
		r = rand_bits(3);
		return {2'b00, r[2:0]};
	endfunction

	function automatic logic [31:0] gen_instr(input int test);
		logic [31:0] r;
		logic [31:0] f;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [3:0]  fk;
		logic [2:0]  ik;
		rs = pick_reg(test);
		rt = pick_reg(test);
		rd = pick_reg(test);
		f  = rand_bits(16);
		r  = rand_bits(3);
		// about one in eight outside the kept set, lw or jr
		if (test == 4 && r == 0) begin
			if (f[0]) begin
				return {6'h23, rs, rt, f[15:0]};
			end
			return {6'h00, rs, rt, rd, 5'd0, 6'h08};
		end
		if (test == 1 || (test != 2 && rand_bits(1) != 0)) begin
			fk = 4'(rand_bits(4) % 11);
			return {6'h00, rs, rt, rd, f[4:0], r_funct[fk]};
		end
		ik = 3'(rand_bits(3) % 7);
		return {i_opcode[ik], rs, rt, f[15:0]};
	endfunction

	task automatic run_test(input int test);
		int sent;
		sent = 0;
		while (sent < test_len) begin
			@(posedge aclk);
			if (instr_valid && instr_ready) begin
				sent++;
			end
			// an offered word stays until it is taken
			if (sent >= test_len) begin
				instr_valid <= 1'b0;
			end else if (!instr_valid || instr_ready) begin
				if (test < 4 || rand_bits(2) != 0) begin
					instr_valid <= 1'b1;
					instr       <= gen_instr(test);
				end else begin
					instr_valid <= 1'b0;
				end
			end
			wb_ready <= (test < 4) || (rand_bits(2) != 0);
		end
	endtask

	task automatic drain_and_report(input int test);
		int waited;
		wb_ready <= 1'b1;
		waited = 0;
		while (pending != 0 && waited < 20) begin
			@(posedge aclk);
			waited++;
		end
		// idle edges so stray writebacks land in this test
		repeat (4) @(posedge aclk);
		test_num  <= test;
		test_done <= 1'b1;
		@(posedge aclk);
		test_done <= 1'b0;
		repeat (2) @(posedge aclk);
	endtask

	pipe_core pipe_core_inst (
		.aclk        (aclk),
		.rst         (rst),
		.instr       (instr),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready),
		.wb_valid    (wb_valid),
		.wb_ready    (wb_ready),
		.wb_reg      (wb_reg),
		.wb_data     (wb_data)
	);

	tb_checker tb_checker_inst (
		.aclk        (aclk),
		.rst         (rst),
		.instr       (instr),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready),
		.wb_valid    (wb_valid),
		.wb_ready    (wb_ready),
		.wb_reg      (wb_reg),
		.wb_data     (wb_data),
		.test_done   (test_done),
		.test_num    (test_num),
		.err_count   (err_count),
		.wb_count    (wb_count),
		.pending     (pending)
	);

	always @(posedge aclk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout: run did not finish within %0d cycles", max_cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	initial begin
		lfsr_state  = 32'hdee4_054c;
		rst         = 1'b0;
		instr       = '0;
		instr_valid = 1'b0;
		wb_ready    = 1'b0;
		test_done   = 1'b0;
		test_num    = 0;
		repeat (10) @(posedge aclk);
		rst      <= 1'b1;
		wb_ready <= 1'b1;
		for (test_idx = 1; test_idx <= num_tests; test_idx++) begin
			run_test(test_idx);
			drain_and_report(test_idx);
		end
		$display("tests %0d, writebacks checked %0d, errors %0d", num_tests, wb_count, err_count);
		if (err_count == 0 && wb_count > 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- sim.f
hdl/core_pkg.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/operand_bypass.sv
hdl/alu.sv
hdl/pipe_core.sv
testbench/tb_checker.sv
testbench/tb_top.sv

//--- run.sh
#!/bin/sh
# build the pipeline testbench with Verilator, run it, scan the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_top -Mdir obj_dir -f sim.f
if ! ./obj_dir/Vtb_top > sim.log 2>&1; then
	cat sim.log
	echo "simulation exited with an error"
	exit 1
fi
cat sim.log
if grep -q '^>>> FAIL$' sim.log; then
	exit 1
fi
exit 0
